/* src/gx_audio_pkg.sv */
package gx_audio_pkg;

    localparam int RAM_ADDR_W = 14;        // ASIC RAM byte address width

    // Effect register block
    localparam logic [15:0] SFX_BASE = 16'hBCE0;
    localparam logic [2:0] SFX_OFS_EN0 = 3'd0;
    localparam logic [2:0] SFX_OFS_EN1 = 3'd1;
    localparam logic [2:0] SFX_OFS_LVL0 = 3'd4;
    localparam logic [2:0] SFX_OFS_LVL1 = 3'd5;

    // DMA channel registers, 4 bytes per channel
    localparam logic [15:0] DMA_BASE = 16'hCC00;
    localparam logic [1:0] DMA_OFS_ADDR_LO = 2'd0;
    localparam logic [1:0] DMA_OFS_ADDR_HI = 2'd1;
    localparam logic [1:0] DMA_OFS_PRESC = 2'd2;
    localparam logic [15:0] DMA_CTRL = 16'hCC0F;
    localparam int CTRL_IRQ_LSB = 4;       // Ack bits on write, flags on read

    // CONTROL command bits
    localparam int CTL_LOOP_BIT = 0;
    localparam int CTL_INT_BIT = 4;
    localparam int CTL_STOP_BIT = 5;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic       addr_lo_we;
        logic       addr_hi_we;
        logic       presc_we;
        logic       start;
        logic       irq_clr;
        logic [7:0] data;
    } chan_wr_t;

    typedef enum logic [3:0] {
        DMA_LOAD    = 4'd0,
        DMA_PAUSE   = 4'd1,
        DMA_REPEAT  = 4'd2,
        DMA_CONTROL = 4'd4
    } dma_op_e;

    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_TICK,
        ACT_STEP,
        ACT_PAUSE,
        ACT_REPEAT,
        ACT_CONTROL
    } chan_act_e;

    typedef struct packed {
        chan_act_e   act;
        logic [11:0] arg;
    } chan_cmd_t;

    typedef struct packed {
        logic                  active;
        logic                  pausing;
        logic                  irq;
        logic [RAM_ADDR_W-1:0] fetch_addr;
    } chan_status_t;

    typedef struct packed {
        logic       wr;
        logic [3:0] regnum;
        logic [7:0] data;
    } psg_write_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SELECT,
        SEQ_FETCH_LO,
        SEQ_FETCH_HI,
        SEQ_EXEC
    } seq_state_e;

endpackage

/* src/sound_regs.sv */
module sound_regs import gx_audio_pkg::*; #(
    parameter int NUM_CHANNELS = 3
) (
    input  logic         clk_sys,
    input  logic         reset,
    input  wb_req_t      wb_req,
    output wb_rsp_t      wb_rsp,
    output chan_wr_t     chan_wr [NUM_CHANNELS],
    input  chan_status_t chan_status [NUM_CHANNELS],
    output logic [1:0]   sfx_en,
    output logic [7:0]   sfx_level_0,
    output logic [7:0]   sfx_level_1
);

    logic       ack_q;
    logic [7:0] dat_q;
    logic       req;        // New request, not yet acked
    logic       wr_cycle;
    logic       in_sfx;
    logic       in_dma;
    logic [1:0] ch_sel;
    logic [7:0] rd_data;
    logic [2:0] act_bits;
    logic [2:0] irq_bits;

    assign req      = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_cycle = req & wb_req.we;
    assign in_sfx   = wb_req.adr[15:3] == SFX_BASE[15:3];
    assign in_dma   = wb_req.adr[15:4] == DMA_BASE[15:4];
    assign ch_sel   = wb_req.adr[3:2];

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (req) dat_q <= rd_data;    // Held while ack is high
    end

    // Effect enables and levels
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sfx_en      <= 2'b00;
            sfx_level_0 <= 8'h00;
            sfx_level_1 <= 8'h00;
        end else if (wr_cycle && in_sfx) begin
            case (wb_req.adr[2:0])
                SFX_OFS_EN0:  sfx_en[0] <= wb_req.dat[0];
                SFX_OFS_EN1:  sfx_en[1] <= wb_req.dat[0];
                SFX_OFS_LVL0: sfx_level_0 <= wb_req.dat;
                SFX_OFS_LVL1: sfx_level_1 <= wb_req.dat;
                default: ;
            endcase
        end
    end

    // Per-channel strobes, applied on the edge that raises ack
    always_comb begin
        for (int n = 0; n < NUM_CHANNELS; n++) begin
            chan_wr[n] = '0;
            chan_wr[n].data = wb_req.dat;
            if (wr_cycle && in_dma && ch_sel == 2'(n)) begin
                chan_wr[n].addr_lo_we = wb_req.adr[1:0] == DMA_OFS_ADDR_LO;
                chan_wr[n].addr_hi_we = wb_req.adr[1:0] == DMA_OFS_ADDR_HI;
                chan_wr[n].presc_we   = wb_req.adr[1:0] == DMA_OFS_PRESC;
            end
            if (wr_cycle && wb_req.adr == DMA_CTRL) begin
                chan_wr[n].start   = wb_req.dat[n];
                chan_wr[n].irq_clr = wb_req.dat[CTRL_IRQ_LSB + n];
            end
        end
    end

    always_comb begin
        act_bits = 3'b000;
        irq_bits = 3'b000;
        for (int n = 0; n < NUM_CHANNELS; n++) begin
            act_bits[n] = chan_status[n].active;
            irq_bits[n] = chan_status[n].irq;
        end
    end

    // Readback, unmapped and write-only addresses give zero
    always_comb begin
        rd_data = 8'h00;
        if (wb_req.adr == DMA_CTRL) begin
            rd_data = {1'b0, irq_bits, 1'b0, act_bits};
        end else if (in_sfx) begin
            case (wb_req.adr[2:0])
                SFX_OFS_EN0:  rd_data = {7'd0, sfx_en[0]};
                SFX_OFS_EN1:  rd_data = {7'd0, sfx_en[1]};
                SFX_OFS_LVL0: rd_data = sfx_level_0;
                SFX_OFS_LVL1: rd_data = sfx_level_1;
                default: ;
            endcase
        end
    end

endmodule

/* src/dma_channel.sv */
module dma_channel import gx_audio_pkg::*; (
    input  logic         clk_sys,
    input  logic         reset,
    input  chan_wr_t     wr,
    input  chan_cmd_t    cmd,
    output chan_status_t status
);

    logic [15:0] addr;
    logic [7:0]  presc;
    logic [7:0]  presc_cnt;
    logic [11:0] pause;
    logic [15:0] loop_addr;
    logic [11:0] loop_cnt;
    logic        active;
    logic        irq;
    logic [15:0] step_addr;

    // Commands are word aligned
    assign step_addr = {addr[15:1], 1'b0} + 16'd2;

    assign status = '{
        active:     active,
        pausing:    pause != 12'd0,
        irq:        irq,
        fetch_addr: {addr[RAM_ADDR_W-1:1], 1'b0}
    };

    // Control state
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            active    <= 1'b0;
            irq       <= 1'b0;
            pause     <= 12'd0;
            presc_cnt <= 8'd0;
            loop_cnt  <= 12'd0;
        end else begin
            case (cmd.act)
                ACT_TICK: begin
                    if (pause != 12'd0) begin
                        if (presc_cnt == 8'd0) begin
                            pause     <= pause - 12'd1;
                            presc_cnt <= presc;
                        end else begin
                            presc_cnt <= presc_cnt - 8'd1;
                        end
                    end
                end
                ACT_PAUSE: begin
                    pause     <= cmd.arg;
                    presc_cnt <= presc;
                end
                ACT_REPEAT: loop_cnt <= cmd.arg;
                ACT_CONTROL: begin
                    if (cmd.arg[CTL_LOOP_BIT] && loop_cnt != 12'd0)
                        loop_cnt <= loop_cnt - 12'd1;
                    if (cmd.arg[CTL_INT_BIT]) irq <= 1'b1;
                    if (cmd.arg[CTL_STOP_BIT]) active <= 1'b0;
                end
                default: ;
            endcase
            if (wr.start) active <= 1'b1;
            if (wr.irq_clr) irq <= 1'b0;    // CPU ack wins over a new INT
        end
    end

    // Address, prescaler and loop point
    always_ff @(posedge clk_sys) begin
        case (cmd.act)
            ACT_STEP, ACT_PAUSE: addr <= step_addr;
            ACT_REPEAT: begin
                addr      <= step_addr;
                loop_addr <= step_addr;     // First command of the body
            end
            ACT_CONTROL: begin
                if (cmd.arg[CTL_LOOP_BIT] && loop_cnt != 12'd0) addr <= loop_addr;
                else addr <= step_addr;
            end
            default: ;
        endcase
        if (wr.addr_lo_we) addr[7:0] <= wr.data;
        if (wr.addr_hi_we) addr[15:8] <= wr.data;
        if (wr.presc_we) presc <= wr.data;
    end

endmodule

/* src/dma_sequencer.sv */
module dma_sequencer import gx_audio_pkg::*; #(
    parameter int NUM_CHANNELS = 3
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dma_hsync_pulse,
    input  chan_status_t          chan_status [NUM_CHANNELS],
    output chan_cmd_t             chan_cmd [NUM_CHANNELS],
    output logic [RAM_ADDR_W-1:0] ram_addr,
    input  logic [7:0]            ram_q,
    output psg_write_t            psg
);

    seq_state_e   state;
    logic [1:0]   ch_q;        // Channel being served
    logic         hsync_q;
    logic         hsync_edge;
    logic         last_ch;
    chan_status_t cur;
    logic [7:0]   cmd_lo;
    logic [7:0]   cmd_hi;
    logic [15:0]  cmd_word;
    dma_op_e      op;
    chan_act_e    cur_act;
    logic         psg_wr_q;
    logic [3:0]   psg_reg_q;
    logic [7:0]   psg_data_q;

    assign hsync_edge = dma_hsync_pulse & ~hsync_q;
    assign last_ch    = ch_q == 2'(NUM_CHANNELS - 1);
    assign cur        = chan_status[ch_q];
    assign cmd_word   = {cmd_hi, cmd_lo};
    assign op         = dma_op_e'(cmd_word[15:12]);

    // Low byte address in SELECT, high byte in FETCH_LO
    assign ram_addr = {cur.fetch_addr[RAM_ADDR_W-1:1], state == SEQ_FETCH_LO};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hsync_q <= 1'b0;
            state   <= SEQ_IDLE;
            ch_q    <= 2'd0;
        end else begin
            hsync_q <= dma_hsync_pulse;
            case (state)
                SEQ_IDLE: begin
                    if (hsync_edge) begin
                        ch_q  <= 2'd0;
                        state <= SEQ_SELECT;
                    end
                end
                SEQ_SELECT: begin
                    if (cur.active && !cur.pausing) begin
                        state <= SEQ_FETCH_LO;
                    end else if (last_ch) begin
                        state <= SEQ_IDLE;  // Idle or pausing, one cycle only
                    end else begin
                        ch_q <= ch_q + 2'd1;
                    end
                end
                SEQ_FETCH_LO: state <= SEQ_FETCH_HI;
                SEQ_FETCH_HI: state <= SEQ_EXEC;
                SEQ_EXEC: begin
                    if (last_ch) begin
                        state <= SEQ_IDLE;
                    end else begin
                        ch_q  <= ch_q + 2'd1;
                        state <= SEQ_SELECT;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Command bytes, little endian
    always_ff @(posedge clk_sys) begin
        if (state == SEQ_FETCH_LO) cmd_lo <= ram_q;
        if (state == SEQ_FETCH_HI) cmd_hi <= ram_q;
    end

    always_comb begin
        cur_act = ACT_NONE;
        if (state == SEQ_SELECT && cur.active && cur.pausing) begin
            cur_act = ACT_TICK;
        end else if (state == SEQ_EXEC) begin
            case (op)
                DMA_PAUSE:   cur_act = ACT_PAUSE;
                DMA_REPEAT:  cur_act = ACT_REPEAT;
                DMA_CONTROL: cur_act = ACT_CONTROL;
                default:     cur_act = ACT_STEP;    // LOAD and NOP
            endcase
        end
        for (int n = 0; n < NUM_CHANNELS; n++) begin
            chan_cmd[n].act = (ch_q == 2'(n)) ? cur_act : ACT_NONE;
            chan_cmd[n].arg = cmd_word[11:0];
        end
    end

    // PSG write goes out the cycle after EXEC
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            psg_wr_q <= 1'b0;
        end else begin
            psg_wr_q <= state == SEQ_EXEC && op == DMA_LOAD;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == SEQ_EXEC) begin
            psg_reg_q  <= cmd_word[11:8];
            psg_data_q <= cmd_word[7:0];
        end
    end

    assign psg = '{wr: psg_wr_q, regnum: psg_reg_q, data: psg_data_q};

endmodule

/* src/audio_mixer.sv */
module audio_mixer (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic [7:0] cpc_audio_l,
    input  logic [7:0] cpc_audio_r,
    input  logic [7:0] psg_ch_a,
    input  logic [7:0] psg_ch_c,
    input  logic [1:0] sfx_en,
    input  logic [7:0] sfx_level_0,
    input  logic [7:0] sfx_level_1,
    output logic [7:0] audio_l,
    output logic [7:0] audio_r
);

    logic [9:0] sum_l;
    logic [9:0] sum_r;

    function automatic logic [7:0] sat8(input logic [9:0] s);
        return (s > 10'd255) ? 8'hFF : s[7:0];
    endfunction

    // Three 8-bit terms fit in 10 bits
    assign sum_l = 10'(cpc_audio_l) + 10'(psg_ch_a)
                 + (sfx_en[0] ? 10'(sfx_level_0) : 10'd0);
    assign sum_r = 10'(cpc_audio_r) + 10'(psg_ch_c)
                 + (sfx_en[1] ? 10'(sfx_level_1) : 10'd0);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_l <= 8'h00;
            audio_r <= 8'h00;
        end else begin
            audio_l <= sat8(sum_l);   // Clamp, no wrap
            audio_r <= sat8(sum_r);
        end
    end

endmodule

/* src/gx4000_audio.sv */
module gx4000_audio import gx_audio_pkg::*; #(
    parameter int NUM_CHANNELS = 3
) (
    input  logic                  clk_sys,
    input  logic                  reset,

    // CPU port
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,

    // Scanline trigger and ASIC RAM
    input  logic                  dma_hsync_pulse,
    output logic [RAM_ADDR_W-1:0] ram_addr,
    input  logic [7:0]            ram_q,

    output psg_write_t            psg,
    output logic                  dma_irq,

    input  logic [7:0]            cpc_audio_l,
    input  logic [7:0]            cpc_audio_r,
    input  logic [7:0]            psg_ch_a,
    input  logic [7:0]            psg_ch_c,
    output logic [7:0]            audio_l,
    output logic [7:0]            audio_r
);

    chan_wr_t               chan_wr [NUM_CHANNELS];
    chan_cmd_t              chan_cmd [NUM_CHANNELS];
    chan_status_t           chan_status [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] irq_flags;
    logic [1:0]             sfx_en;
    logic [7:0]             sfx_level_0;
    logic [7:0]             sfx_level_1;

    sound_regs #(.NUM_CHANNELS(NUM_CHANNELS)) u_regs (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .chan_wr     (chan_wr),
        .chan_status (chan_status),
        .sfx_en      (sfx_en),
        .sfx_level_0 (sfx_level_0),
        .sfx_level_1 (sfx_level_1)
    );

    for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_chan
        dma_channel u_chan (
            .clk_sys (clk_sys),
            .reset   (reset),
            .wr      (chan_wr[n]),
            .cmd     (chan_cmd[n]),
            .status  (chan_status[n])
        );
        assign irq_flags[n] = chan_status[n].irq;
    end

    assign dma_irq = |irq_flags;

    dma_sequencer #(.NUM_CHANNELS(NUM_CHANNELS)) u_seq (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dma_hsync_pulse (dma_hsync_pulse),
        .chan_status     (chan_status),
        .chan_cmd        (chan_cmd),
        .ram_addr        (ram_addr),
        .ram_q           (ram_q),
        .psg             (psg)
    );

    audio_mixer u_mix (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .cpc_audio_l (cpc_audio_l),
        .cpc_audio_r (cpc_audio_r),
        .psg_ch_a    (psg_ch_a),
        .psg_ch_c    (psg_ch_c),
        .sfx_en      (sfx_en),
        .sfx_level_0 (sfx_level_0),
        .sfx_level_1 (sfx_level_1),
        .audio_l     (audio_l),
        .audio_r     (audio_r)
    );

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk_sys,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;    // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk_sys);
        #1 reset = 1'b0;
    end

endmodule

/* sim/gx4000_audio_chk.sv */
module gx4000_audio_chk import gx_audio_pkg::*; (
    input logic       clk_sys,
    input logic       reset,
    input wb_req_t    wb_req,
    input wb_rsp_t    wb_rsp,
    input psg_write_t psg,
    input logic       dma_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    // One-cycle ack, never back to back
    ack_single: assert property (@(posedge clk_sys) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for two cycles");

    // Ack only answers a request
    ack_after_req: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a request");

    psg_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        psg.wr |=> !psg.wr)
        else $error("psg write pulse longer than one cycle");

    // Outputs quiet during reset, once the first reset edge has passed
    reset_quiet: assert property (@(posedge clk_sys)
        reset && $past(reset) |-> !dma_irq && !psg.wr && !wb_rsp.ack)
        else $error("output active during reset");

endmodule

bind gx4000_audio gx4000_audio_chk chk (
    .clk_sys (clk_sys),
    .reset   (reset),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .psg     (psg),
    .dma_irq (dma_irq)
);

/* sim/gx4000_audio_tb.sv */
module gx4000_audio_tb import gx_audio_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [2:0] K_WR = 3'd0;
    localparam logic [2:0] K_RD = 3'd1;
    localparam logic [2:0] K_LINE = 3'd2;
    localparam logic [2:0] K_MIX = 3'd3;
    localparam logic [2:0] K_IRQ = 3'd4;

    typedef struct packed {
        logic [2:0]       kind;
        logic [15:0]      adr;
        logic [7:0]       dat;       // Write data, read expectation or vector count
        logic [1:0]       n_psg;
        logic [2:0][11:0] psg_exp;   // {regnum, data} in channel order
    } step_t;

    logic                  clk_sys;
    logic                  reset;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic                  dma_hsync_pulse;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [7:0]            ram_q = 8'h00;
    psg_write_t            psg;
    logic                  dma_irq;
    logic [7:0]            cpc_audio_l;
    logic [7:0]            cpc_audio_r;
    logic [7:0]            psg_ch_a;
    logic [7:0]            psg_ch_c;
    logic [7:0]            audio_l;
    logic [7:0]            audio_r;

    logic [7:0]            ram [0:(1<<RAM_ADDR_W)-1];
    logic [RAM_ADDR_W-1:0] ram_rd_addr;
    step_t                 steps [$];
    int                    errors = 0;
    int                    failures = 0;    // Timeouts and other non-value failures
    logic [31:0]           lfsr_state = 32'had4c;
    logic [1:0]            sh_en = 2'b00;   // Shadow of the effect registers
    logic [7:0]            sh_lvl0 = 8'h00;
    logic [7:0]            sh_lvl1 = 8'h00;

    tb_clock u_clk (.clk_sys(clk_sys), .reset(reset));

    gx4000_audio #(.NUM_CHANNELS(3)) uut (.*);

    // ASIC RAM, address taken at the edge and data out 1 ns later
    always @(posedge clk_sys) begin
        ram_rd_addr = ram_addr;
        #1 ram_q = ram[ram_rd_addr];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [7:0] rand_byte();
        logic [7:0] r;
        r = 8'h00;
        for (int i = 0; i < 8; i++) begin
            r = {r[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic put_cmd(input int a, input logic [15:0] w);
        ram[a] = w[7:0];          // Little endian
        ram[a + 1] = w[15:8];
    endtask

    task automatic load_ram();
        for (int i = 0; i < (1 << RAM_ADDR_W); i++) ram[i] = 8'(i * 7 + (i >> 8));
        // Channel 0 exercises pause, repeat, loop, int and stop
        put_cmd('h100, 16'h0111);
        put_cmd('h102, 16'h1002);
        put_cmd('h104, 16'h0222);
        put_cmd('h106, 16'h2001);
        put_cmd('h108, 16'h0333);
        put_cmd('h10A, 16'h4001);
        put_cmd('h10C, 16'h0444);
        put_cmd('h10E, 16'h4030);
        for (int i = 0; i < 16; i++) put_cmd('h200 + 2 * i, 16'h0500 | 16'(i + 1));
        put_cmd('h300, 16'h0666);
        put_cmd('h302, 16'h4020);
    endtask

    task automatic add(input logic [2:0] k, input logic [15:0] a, input logic [7:0] d);
        steps.push_back('{kind: k, adr: a, dat: d, n_psg: 2'd0, psg_exp: '0});
    endtask

    task automatic add_line(input logic [1:0] n, input logic [11:0] e0,
                            input logic [11:0] e1, input logic [11:0] e2);
        steps.push_back('{kind: K_LINE, adr: 16'h0, dat: 8'h0, n_psg: n,
                          psg_exp: {e2, e1, e0}});
    endtask

    task automatic build_table();
        add(K_RD, DMA_CTRL, 8'h00);
        add(K_IRQ, 16'h0, 8'h00);
        add(K_WR, 16'hBCE4, 8'h5A);
        add(K_RD, 16'hBCE4, 8'h5A);
        add(K_WR, 16'hBCE5, 8'hC3);
        add(K_RD, 16'hBCE5, 8'hC3);
        add(K_WR, 16'hBCE0, 8'h01);
        add(K_RD, 16'hBCE0, 8'h01);
        add(K_WR, 16'hBCE1, 8'hFF);
        add(K_RD, 16'hBCE1, 8'h01);    // Enable is one bit wide
        add(K_WR, 16'h1234, 8'h77);
        add(K_RD, 16'h1234, 8'h00);
        add(K_RD, 16'hCC03, 8'h00);
        add(K_MIX, 16'h0, 8'd40);
        add(K_WR, 16'hBCE0, 8'h00);
        add(K_MIX, 16'h0, 8'd40);
        add(K_WR, 16'hBCE1, 8'h00);
        add(K_MIX, 16'h0, 8'd40);
        // Channel 0 at 0x100 prescaler 1, channel 1 at 0x200, channel 2 at 0x300
        add(K_WR, 16'hCC00, 8'h00);
        add(K_WR, 16'hCC01, 8'h01);
        add(K_WR, 16'hCC02, 8'h01);
        add(K_WR, 16'hCC04, 8'h00);
        add(K_WR, 16'hCC05, 8'h02);
        add(K_WR, 16'hCC06, 8'h00);
        add(K_WR, 16'hCC08, 8'h00);
        add(K_WR, 16'hCC09, 8'h03);
        add(K_WR, 16'hCC0A, 8'h00);
        add(K_WR, DMA_CTRL, 8'h03);
        add(K_RD, DMA_CTRL, 8'h03);
        add_line(2'd2, 12'h111, 12'h501, 12'h0);
        add(K_WR, DMA_CTRL, 8'h04);
        add(K_RD, DMA_CTRL, 8'h07);
        add_line(2'd2, 12'h502, 12'h666, 12'h0);    // Channel 0 takes PAUSE 2
        add_line(2'd1, 12'h503, 12'h0, 12'h0);      // Channel 2 stops
        add(K_RD, DMA_CTRL, 8'h03);
        add_line(2'd1, 12'h504, 12'h0, 12'h0);
        add_line(2'd1, 12'h505, 12'h0, 12'h0);
        add_line(2'd1, 12'h506, 12'h0, 12'h0);
        add_line(2'd2, 12'h222, 12'h507, 12'h0);    // 2*(1+1) lines skipped
        add_line(2'd1, 12'h508, 12'h0, 12'h0);      // REPEAT 1
        add_line(2'd2, 12'h333, 12'h509, 12'h0);
        add_line(2'd1, 12'h50A, 12'h0, 12'h0);
        add_line(2'd2, 12'h333, 12'h50B, 12'h0);
        add_line(2'd1, 12'h50C, 12'h0, 12'h0);
        add_line(2'd2, 12'h444, 12'h50D, 12'h0);
        add_line(2'd1, 12'h50E, 12'h0, 12'h0);      // INT and STOP on channel 0
        add(K_IRQ, 16'h0, 8'h01);
        add(K_RD, DMA_CTRL, 8'h12);
        add(K_WR, DMA_CTRL, 8'h10);
        add(K_RD, DMA_CTRL, 8'h02);
        add(K_IRQ, 16'h0, 8'h00);
        add_line(2'd1, 12'h50F, 12'h0, 12'h0);
    endtask

    task automatic wb_access(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdat);
        int  cnt;
        bit  got;
        cnt = 0;
        got = 0;
        rdat = 8'h00;
        @(posedge clk_sys);
        #1 wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!got && cnt < 20) begin
            @(negedge clk_sys);
            cnt++;
            if (wb_rsp.ack) begin
                got = 1;
                rdat = wb_rsp.dat;
            end
        end
        @(posedge clk_sys);
        #1 wb_req = '0;
        if (!got) begin
            failures++;
            $display("No ack from the register port at address %h", adr);
        end
    endtask

    task automatic run_line(input int idx, input step_t s);
        logic [11:0] got [4];
        int          n_got;
        int          wait_cnt;
        int          tail;
        bit          started;
        bit          done;
        n_got = 0;
        wait_cnt = 0;
        tail = 0;
        started = 0;
        done = 0;
        @(posedge clk_sys);
        #1 dma_hsync_pulse = 1'b1;
        @(posedge clk_sys);
        #1 dma_hsync_pulse = 1'b0;
        // Two extra cycles catch the write that trails EXEC
        while (tail < 2 && wait_cnt < 40) begin
            @(negedge clk_sys);
            wait_cnt++;
            if (done) tail++;
            if (psg.wr) begin
                if (n_got < 4) got[n_got] = {psg.regnum, psg.data};
                n_got++;
            end
            if (uut.u_seq.state != SEQ_IDLE) started = 1;
            else if (started) done = 1;
        end
        if (!done) begin
            failures++;
            $display("Scanline pass of step %0d did not finish in time", idx);
        end
        check($sformatf("step %0d psg count", idx), 32'(s.n_psg), 32'(n_got));
        for (int k = 0; k < int'(s.n_psg) && k < n_got; k++)
            check($sformatf("step %0d psg write %0d", idx, k), 32'(s.psg_exp[k]), 32'(got[k]));
        repeat (4) @(posedge clk_sys);    // Keep scanline edges apart
    endtask

    task automatic run_mix(input int idx, input int count);
        int exp_l;
        int exp_r;
        for (int v = 0; v < count; v++) begin
            @(posedge clk_sys);
            #1;
            cpc_audio_l = rand_byte();
            cpc_audio_r = rand_byte();
            psg_ch_a = rand_byte();
            psg_ch_c = rand_byte();
            exp_l = int'(cpc_audio_l) + int'(psg_ch_a) + (sh_en[0] ? int'(sh_lvl0) : 0);
            exp_r = int'(cpc_audio_r) + int'(psg_ch_c) + (sh_en[1] ? int'(sh_lvl1) : 0);
            if (exp_l > 255) exp_l = 255;
            if (exp_r > 255) exp_r = 255;
            @(posedge clk_sys);    // One cycle latency
            @(negedge clk_sys);
            check($sformatf("step %0d mix %0d left", idx, v), 32'(exp_l), 32'(audio_l));
            check($sformatf("step %0d mix %0d right", idx, v), 32'(exp_r), 32'(audio_r));
        end
    endtask

    initial begin
        logic [7:0] rd;
        int         cnt;
        wb_req = '0;
        dma_hsync_pulse = 1'b0;
        cpc_audio_l = 8'h00;
        cpc_audio_r = 8'h00;
        psg_ch_a = 8'h00;
        psg_ch_c = 8'h00;
        load_ram();
        build_table();
        cnt = 0;
        while (reset !== 1'b0 && cnt < 100) begin
            @(posedge clk_sys);
            cnt++;
        end
        if (reset !== 1'b0) begin
            failures++;
            $display("Reset was never released");
        end
        @(negedge clk_sys);
        check("reset audio_l", 32'h0, 32'(audio_l));
        check("reset audio_r", 32'h0, 32'(audio_r));
        check("reset psg wr", 32'h0, 32'(psg.wr));

        foreach (steps[i]) begin
            case (steps[i].kind)
                K_WR: begin
                    wb_access(1'b1, steps[i].adr, steps[i].dat, rd);
                    if (steps[i].adr == 16'hBCE0) sh_en[0] = steps[i].dat[0];
                    if (steps[i].adr == 16'hBCE1) sh_en[1] = steps[i].dat[0];
                    if (steps[i].adr == 16'hBCE4) sh_lvl0 = steps[i].dat;
                    if (steps[i].adr == 16'hBCE5) sh_lvl1 = steps[i].dat;
                end
                K_RD: begin
                    wb_access(1'b0, steps[i].adr, 8'h00, rd);
                    check($sformatf("step %0d read %h", i, steps[i].adr),
                          32'(steps[i].dat), 32'(rd));
                end
                K_LINE: run_line(i, steps[i]);
                K_MIX: run_mix(i, int'(steps[i].dat));
                K_IRQ: begin
                    @(negedge clk_sys);
                    check($sformatf("step %0d dma_irq", i), 32'(steps[i].dat[0]), 32'(dma_irq));
                end
                default: begin
                    failures++;
                    $display("Unknown step kind at step %0d", i);
                end
            endcase
        end

        $display("Done: %0d mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/gx_audio_pkg.sv
src/sound_regs.sv
src/dma_channel.sv
src/dma_sequencer.sv
src/audio_mixer.sv
src/gx4000_audio.sv
sim/tb_clock.sv
sim/gx4000_audio_chk.sv
sim/gx4000_audio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gx4000_audio_tb -f filelist.f -o sim_gx4000_audio

./obj_dir/sim_gx4000_audio > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0
